/* hdl/soundIoPkg.sv */
package soundIoPkg;

  ////////////////////////////////////////
  // bus types
  ////////////////////////////////////////

  typedef logic [15:0] busAddr_t;
  typedef logic [7:0]  busData_t;

  // one CPU bus cycle as seen by the sound side
  typedef struct packed {
    busAddr_t addr;
    busData_t data;
    logic     we;
  } busWrite_t;

  // board variant
  typedef enum logic [1:0] {
    gameBattlezone,
    gameRedBaron,
    gameTempest
  } gameSel_t;

  // main output latch at 1840h with msb first
  typedef struct packed {
    logic       motorA;
    logic       spare;
    logic       soundEnable;
    logic       motorB;
    logic [3:0] triggers;
  } outLatch_t;

  typedef logic [15:0] lfsr_t;

  ////////////////////////////////////////
  // decode addresses
  ////////////////////////////////////////

  localparam busAddr_t mainLatchAddr     = 16'h1840;
  localparam busAddr_t redBaronLatchAddr = 16'h1808;
  localparam busAddr_t pokeyBzBase       = 16'h1820;
  localparam busAddr_t pokeyRbBase       = 16'h1810;
  localparam busAddr_t pokeyTempest1Base = 16'h60C0;
  localparam busAddr_t pokeyTempest2Base = 16'h60D0;
  localparam busAddr_t pokeyWindow       = 16'h0010;

  // nmi cadence, counted in nmi ticks
  localparam logic [3:0] nmiPeriodTicks = 4'd14;
  localparam logic [3:0] nmiRaiseTick   = 4'd12;

endpackage

/* hdl/timingGen.sv */
`timescale 1ns/1ps

module timingGen import soundIoPkg::*; #(
  parameter int cpuDivLog2  = 4,
  parameter int tickDivLog2 = 14
) (
  input  logic clk,
  input  logic rst,
  output logic cpuEn,
  output logic noiseEn,
  output logic nmi
);

  ////////////////////////////////////////
  // free-running dividers
  ////////////////////////////////////////

  logic [cpuDivLog2-1:0]  cpuCnt;
  logic [tickDivLog2-1:0] tickCnt;
  // noise runs at twice the nmi tick rate
  logic [tickDivLog2-2:0] noiseCnt;
  logic                   nmiTick;

  always_ff @(posedge clk) begin
    if (rst) begin
      cpuCnt   <= '0;
      tickCnt  <= '0;
      noiseCnt <= '0;
    end else begin
      cpuCnt   <= cpuCnt + 1'b1;
      tickCnt  <= tickCnt + 1'b1;
      noiseCnt <= noiseCnt + 1'b1;
    end
  end

  // one-clock pulses on the terminal count
  assign cpuEn   = &cpuCnt;
  assign nmiTick = &tickCnt;
  assign noiseEn = &noiseCnt;

  ////////////////////////////////////////
  // nmi timer
  ////////////////////////////////////////

  logic [3:0] nmiCnt;

  // 14 ticks per period with nmi held for the tick after count 12
  always_ff @(posedge clk) begin
    if (rst) begin
      nmiCnt <= '0;
      nmi    <= 1'b0;
    end else if (nmiTick) begin
      nmi <= (nmiCnt == nmiRaiseTick);
      if (nmiCnt == nmiPeriodTicks - 1'b1) begin
        nmiCnt <= '0;
      end else begin
        nmiCnt <= nmiCnt + 1'b1;
      end
    end
  end

  // nmi level only moves on the clock following a tick
  nmiOnTickOnly: assert property (
    @(posedge clk) disable iff (rst)
    !$past(nmiTick) |-> $stable(nmi)
  ) else $error("nmi changed without an nmi tick");

endmodule

/* hdl/soundBusPort.sv */
`timescale 1ns/1ps

module soundBusPort import soundIoPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      cpuEn,
  input  busWrite_t bus,
  input  gameSel_t  gameSel,
  output outLatch_t mainLatch,
  output busData_t  audioSel,
  output logic      pokey1SelN,
  output logic      pokey2SelN
);

  // true when addr falls in [base, base + pokeyWindow)
  function automatic logic inWindow(input busAddr_t addr, input busAddr_t base);
    logic aboveBase;
    logic belowTop;
    aboveBase = (addr >= base);
    belowTop  = (addr < base + pokeyWindow);
    return aboveBase && belowTop;
  endfunction

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////

  logic     writeStrobe;
  logic     mainHit;
  logic     redBaronHit;
  busData_t redBaronLatch;

  // writes only count on the cpu enable
  assign writeStrobe = cpuEn && bus.we;
  assign mainHit     = writeStrobe && (bus.addr == mainLatchAddr);
  assign redBaronHit = writeStrobe && (bus.addr == redBaronLatchAddr);

  always_ff @(posedge clk) begin
    if (rst) begin
      mainLatch <= '0;
    end else if (mainHit) begin
      mainLatch <= outLatch_t'(bus.data);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      redBaronLatch <= '0;
    end else if (redBaronHit) begin
      redBaronLatch <= bus.data;
    end
  end

  // red baron reads back its own latch
  assign audioSel = (gameSel == gameRedBaron) ? redBaronLatch : busData_t'(mainLatch);

  ////////////////////////////////////////
  // pokey chip selects
  ////////////////////////////////////////

  busAddr_t pokey1Base;

  always_comb begin
    case (gameSel)
      gameRedBaron: pokey1Base = pokeyRbBase;
      gameTempest:  pokey1Base = pokeyTempest1Base;
      default:      pokey1Base = pokeyBzBase;
    endcase
  end

  assign pokey1SelN = !inWindow(bus.addr, pokey1Base);

  // second pokey only exists on tempest
  // other boards hold the select low
  assign pokey2SelN = (gameSel == gameTempest) ? !inWindow(bus.addr, pokeyTempest2Base)
                                               : 1'b0;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  latchOnCpuEn: assert property (
    @(posedge clk) disable iff (rst)
    !$past(cpuEn) |-> ($stable(mainLatch) && $stable(redBaronLatch))
  ) else $error("output latch changed outside a cpu cycle");

endmodule

/* hdl/discreteSound.sv */
`timescale 1ns/1ps

module discreteSound import soundIoPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       noiseEn,
  input  outLatch_t  mainLatch,
  output logic       ampSd,
  output logic [7:0] soundCtrl
);

  logic  soundEnable;
  lfsr_t lfsr;
  logic  feedback;
  logic  noiseOut0;
  logic  noiseOut1;
  logic  toggle0;
  logic  toggle1;

  assign soundEnable = mainLatch.soundEnable;
  // amp shutdown follows the enable bit directly
  assign ampSd = soundEnable;

  ////////////////////////////////////////
  // noise lfsr
  ////////////////////////////////////////

  assign feedback = ~(lfsr[3] ^ lfsr[14]);

  // held at zero while sound is off
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= '0;
    end else if (noiseEn) begin
      if (!soundEnable) begin
        lfsr <= '0;
      end else begin
        lfsr <= {lfsr[14:0], feedback};
      end
    end
  end

  // toggle taps
  assign noiseOut0 = lfsr[15];
  assign noiseOut1 = !(&lfsr[14:11]);

  always_ff @(posedge clk) begin
    if (rst) begin
      toggle0 <= 1'b0;
      toggle1 <= 1'b0;
    end else if (noiseEn) begin
      if (noiseOut0) begin
        toggle0 <= ~toggle0;
      end
      if (noiseOut1) begin
        toggle1 <= ~toggle1;
      end
    end
  end

  ////////////////////////////////////////
  // discrete port, active low
  ////////////////////////////////////////

  always_comb begin
    soundCtrl[0] = ~mainLatch.triggers[3];
    soundCtrl[1] = ~mainLatch.triggers[2];
    soundCtrl[2] = ~toggle0;
    soundCtrl[3] = ~mainLatch.triggers[1];
    soundCtrl[4] = ~mainLatch.triggers[0];
    soundCtrl[5] = ~toggle1;
    // motors parked while sound is disabled
    if (soundEnable) begin
      soundCtrl[6] = ~mainLatch.motorA;
      soundCtrl[7] = ~mainLatch.motorB;
    end else begin
      soundCtrl[6] = 1'b1;
      soundCtrl[7] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  lfsrClearedWhenOff: assert property (
    @(posedge clk) disable iff (rst)
    ($past(noiseEn) && !$past(soundEnable)) |-> (lfsr == '0)
  ) else $error("lfsr running with sound disabled");

endmodule

/* hdl/arcadeSoundIo.sv */
`timescale 1ns/1ps

module arcadeSoundIo import soundIoPkg::*; #(
  parameter int cpuDivLog2  = 4,
  parameter int tickDivLog2 = 14
) (
  input  logic       clk,
  input  logic       rst,
  input  busWrite_t  bus,
  input  gameSel_t   gameSel,
  output logic       nmi,
  output logic       cpuEn,
  output logic       pokey1SelN,
  output logic       pokey2SelN,
  output busData_t   audioSel,
  output logic       ampSd,
  output logic [7:0] soundCtrl
);

  logic      noiseEn;
  outLatch_t mainLatch;

  ////////////////////////////////////////
  // clock enables and nmi
  ////////////////////////////////////////

  timingGen #(
    .cpuDivLog2  (cpuDivLog2),
    .tickDivLog2 (tickDivLog2)
  ) i_timingGen (
    .clk     (clk),
    .rst     (rst),
    .cpuEn   (cpuEn),
    .noiseEn (noiseEn),
    .nmi     (nmi)
  );

  // cpu writes into latches and pokey selects
  soundBusPort i_soundBusPort (
    .clk        (clk),
    .rst        (rst),
    .cpuEn      (cpuEn),
    .bus        (bus),
    .gameSel    (gameSel),
    .mainLatch  (mainLatch),
    .audioSel   (audioSel),
    .pokey1SelN (pokey1SelN),
    .pokey2SelN (pokey2SelN)
  );

  ////////////////////////////////////////
  // discrete sound port
  ////////////////////////////////////////

  discreteSound i_discreteSound (
    .clk       (clk),
    .rst       (rst),
    .noiseEn   (noiseEn),
    .mainLatch (mainLatch),
    .ampSd     (ampSd),
    .soundCtrl (soundCtrl)
  );

endmodule

/* verification/arcadeSoundIoTb.sv */
`timescale 1ns/1ps

module arcadeSoundIoTb import soundIoPkg::*; ();

  localparam int cpuDivLog2    = 2;
  localparam int tickDivLog2   = 6;
  localparam int clkPeriod     = 100;
  localparam int resetCycles   = 4;
  localparam int cpuClocks     = 1 << cpuDivLog2;
  localparam int tickClocks    = 1 << tickDivLog2;
  localparam int noiseClocks   = tickClocks / 2;
  localparam int ticksPerNmi   = 14;
  localparam int randomSeed    = 80569;

  // one row of the cases file
  typedef struct packed {
    gameSel_t  game;
    busWrite_t bus;
    busData_t  expAudio;
    logic      expSel1;
    logic      expSel2;
  } caseEntry_t;

  logic        clk;
  logic        rst;
  busWrite_t   bus;
  gameSel_t    gameSel;
  logic        nmi;
  logic        cpuEn;
  logic        pokey1SelN;
  logic        pokey2SelN;
  busData_t    audioSel;
  logic        ampSd;
  logic [7:0]  soundCtrl;

  caseEntry_t  caseQueue[$];
  busData_t    mainModel;
  int          errorCount;
  int          testCount;
  int          failedTests;
  int          cycleCount;
  int          cycleLimit;
  int          caseTotal;
  int unsigned seedInit;

  arcadeSoundIo #(
    .cpuDivLog2  (cpuDivLog2),
    .tickDivLog2 (tickDivLog2)
  ) i_arcadeSoundIo (
    .clk        (clk),
    .rst        (rst),
    .bus        (bus),
    .gameSel    (gameSel),
    .nmi        (nmi),
    .cpuEn      (cpuEn),
    .pokey1SelN (pokey1SelN),
    .pokey2SelN (pokey2SelN),
    .audioSel   (audioSel),
    .ampSd      (ampSd),
    .soundCtrl  (soundCtrl)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // watchdog limit is set once the cases are loaded
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout: run went past %0d clock cycles", cycleLimit);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic int loadCases();
    int          fd;
    int          status;
    int          fields;
    string       line;
    logic [31:0] game;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] we;
    logic [31:0] expAudio;
    logic [31:0] expSel1;
    logic [31:0] expSel2;
    caseEntry_t  entry;
    fd = $fopen("verification/soundCases.txt", "r");
    if (fd == 0) begin
      return -1;
    end
    while (!$feof(fd)) begin
      status = $fgets(line, fd);
      if (status > 0) begin
        // comment and blank lines never scan to seven fields
        fields = $sscanf(line, "%h %h %h %h %h %h %h",
                         game, addr, data, we, expAudio, expSel1, expSel2);
        if (fields == 7) begin
          entry.game     = gameSel_t'(game[1:0]);
          entry.bus      = {addr[15:0], data[7:0], we[0]};
          entry.expAudio = expAudio[7:0];
          entry.expSel1  = expSel1[0];
          entry.expSel2  = expSel2[0];
          caseQueue.push_back(entry);
        end
      end
    end
    $fclose(fd);
    return caseQueue.size();
  endfunction

  // discrete port from the main latch byte with the toggle bits as they are
  function automatic logic [7:0] expectedCtrl(input busData_t latchByte,
                                              input logic [7:0] current);
    logic [7:0] ctrl;
    ctrl[0] = ~latchByte[3];
    ctrl[1] = ~latchByte[2];
    ctrl[2] = current[2];
    ctrl[3] = ~latchByte[1];
    ctrl[4] = ~latchByte[0];
    ctrl[5] = current[5];
    ctrl[6] = latchByte[5] ? ~latchByte[7] : 1'b1;
    ctrl[7] = latchByte[5] ? ~latchByte[4] : 1'b1;
    return ctrl;
  endfunction

  task automatic compareValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected 0x%0h got 0x%0h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testCount++;
    if (errorCount == errBefore) begin
      $display("%s: ok", name);
    end else begin
      failedTests++;
      $display("%s: failed", name);
    end
  endtask

  // returns on the falling edge where cpuEn is high
  task automatic waitCpuEn();
    @(negedge clk);
    while (!cpuEn) begin
      @(negedge clk);
    end
  endtask

  // hold the bus across two cpu pulses and return one clock after the second
  task automatic applyWrite(input gameSel_t game, input busAddr_t addr,
                            input busData_t data, input logic we);
    int pulseGap;
    @(posedge clk);
    bus     <= {addr, data, we};
    gameSel <= game;
    waitCpuEn();
    // spacing between the two pulses
    @(negedge clk);
    pulseGap = 1;
    while (!cpuEn) begin
      @(negedge clk);
      pulseGap++;
    end
    compareValue("cpuEn period", cpuClocks, pulseGap);
    @(negedge clk);
    compareValue("cpuEn", 0, cpuEn);
    if (we && addr == 16'h1840) begin
      mainModel = data;
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic resetStateTest();
    int errBefore;
    errBefore = errorCount;
    repeat (resetCycles - 1) @(posedge clk);
    @(negedge clk);
    compareValue("nmi", 0, nmi);
    compareValue("cpuEn", 0, cpuEn);
    compareValue("audioSel", 0, audioSel);
    compareValue("ampSd", 0, ampSd);
    compareValue("soundCtrl", 16'hff, soundCtrl);
    reportTest("reset state", errBefore);
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic replayCases();
    int         idx;
    int         gap;
    int         errBefore;
    caseEntry_t entry;
    for (idx = 0; idx < caseQueue.size(); idx++) begin
      gap = $urandom % 4;
      if (gap > 0) begin
        @(posedge clk);
        bus <= '0;
        repeat (gap) waitCpuEn();
      end
      entry = caseQueue[idx];
      errBefore = errorCount;
      applyWrite(entry.game, entry.bus.addr, entry.bus.data, entry.bus.we);
      compareValue("audioSel", entry.expAudio, audioSel);
      compareValue("pokey1SelN", entry.expSel1, pokey1SelN);
      compareValue("pokey2SelN", entry.expSel2, pokey2SelN);
      compareValue("soundCtrl", expectedCtrl(mainModel, soundCtrl), soundCtrl);
      compareValue("ampSd", mainModel[5], ampSd);
      reportTest($sformatf("case %0d addr %h", idx + 1, entry.bus.addr), errBefore);
    end
  endtask

  task automatic nmiPeriodTest();
    int   errBefore;
    int   clocks;
    int   highClocks;
    logic prevNmi;
    logic rose;
    errBefore = errorCount;
    // sync to a rising edge first
    prevNmi = 1'b1;
    rose    = 1'b0;
    while (!rose) begin
      @(negedge clk);
      rose    = nmi && !prevNmi;
      prevNmi = nmi;
    end
    clocks     = 0;
    highClocks = 1;
    rose       = 1'b0;
    while (!rose) begin
      @(negedge clk);
      clocks++;
      if (nmi && !prevNmi) begin
        rose = 1'b1;
      end else if (nmi) begin
        highClocks++;
      end
      prevNmi = nmi;
    end
    compareValue("nmi period", ticksPerNmi * tickClocks, clocks);
    compareValue("nmi high time", tickClocks, highClocks);
    reportTest("nmi period", errBefore);
  endtask

  task automatic noiseToggleTest();
    int   errBefore;
    int   clocks;
    int   tick;
    logic prevBit;
    logic startBit;
    logic bit2Moved;
    errBefore = errorCount;
    applyWrite(gameBattlezone, 16'h1840, 8'h00, 1'b1);
    compareValue("audioSel", 8'h00, audioSel);
    compareValue("ampSd", 0, ampSd);
    // a tick or two flushes whatever the lfsr held
    repeat (2 * noiseClocks) @(negedge clk);
    prevBit = soundCtrl[5];
    clocks  = 0;
    while (soundCtrl[5] === prevBit && clocks <= noiseClocks) begin
      @(negedge clk);
      clocks++;
    end
    bit2Moved = 1'b0;
    for (tick = 0; tick < 6; tick++) begin
      prevBit = soundCtrl[5];
      clocks  = 0;
      while (soundCtrl[5] === prevBit && clocks <= noiseClocks) begin
        @(negedge clk);
        clocks++;
        if (soundCtrl[2] !== 1'b1) begin
          bit2Moved = 1'b1;
        end
      end
      compareValue("soundCtrl[5] interval", noiseClocks, clocks);
    end
    if (bit2Moved) begin
      $display("soundCtrl bit 2 left 1 while sound was disabled");
      errorCount++;
    end
    // first bit shifted into the cleared lfsr is a one
    // it reaches bit 15 and toggle0 after 16 ticks
    applyWrite(gameBattlezone, 16'h1840, 8'h20, 1'b1);
    compareValue("audioSel", 8'h20, audioSel);
    compareValue("ampSd", 1, ampSd);
    startBit = soundCtrl[2];
    clocks   = 0;
    while (soundCtrl[2] === startBit && clocks < 20 * noiseClocks) begin
      @(negedge clk);
      clocks++;
    end
    if (soundCtrl[2] === startBit) begin
      $display("soundCtrl bit 2 did not change within 20 noise ticks of sound enable");
      errorCount++;
    end
    reportTest("noise toggles", errBefore);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    bus         = '0;
    gameSel     = gameBattlezone;
    mainModel   = '0;
    errorCount  = 0;
    testCount   = 0;
    failedTests = 0;
    cycleCount  = 0;
    cycleLimit  = 0;
    seedInit    = $urandom(randomSeed);
    caseTotal   = loadCases();
    if (caseTotal <= 0) begin
      $display("no cases could be read from verification/soundCases.txt");
      $display("Checks failed");
      $finish;
    end else begin
      cycleLimit = caseTotal * 8 * cpuClocks + 30 * tickClocks;
      resetStateTest();
      replayCases();
      // nmi only observes so both run side by side
      fork
        nmiPeriodTest();
        noiseToggleTest();
      join
      $display("tests %0d, failed tests %0d, check errors %0d",
               testCount, failedTests, errorCount);
      if (errorCount == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

/* verification/soundCases.txt */
# columns, all hex: game addr data we | expected audioSel pokey1SelN pokey2SelN
# game 0 battlezone, 1 red baron, 2 tempest
# main latch writes
0 1840 a5 1 a5 1 0
0 1840 3c 1 3c 1 0
0 1840 20 1 20 1 0
0 1840 ff 1 ff 1 0
0 1840 00 1 00 1 0
0 1840 6a 1 6a 1 0
# ignored writes and the red baron latch
0 1840 11 0 6a 1 0
0 1841 22 1 6a 1 0
0 183f 33 1 6a 1 0
0 0840 44 1 6a 1 0
0 1808 5a 1 6a 1 0
1 1808 5a 0 5a 1 0
1 1808 c3 1 c3 1 0
1 1840 99 1 c3 1 0
0 1840 99 0 99 1 0
2 1808 12 0 99 1 1
1 1809 77 1 c3 1 0
# battlezone pokey window
0 1820 00 0 99 0 0
0 182f 00 0 99 0 0
0 181f 00 0 99 1 0
0 1830 00 0 99 1 0
0 1825 00 0 99 0 0
# red baron pokey window
1 1810 00 0 c3 0 0
1 181f 00 0 c3 0 0
1 180f 00 0 c3 1 0
1 1820 00 0 c3 1 0
# tempest pokey windows
2 60c0 00 0 99 0 1
2 60cf 00 0 99 0 1
2 60bf 00 0 99 1 1
2 60d0 00 0 99 1 0
2 60df 00 0 99 1 0
2 60e0 00 0 99 1 1
2 1820 00 0 99 1 1
0 60c0 00 0 99 1 0
# latch writes across games
2 1840 8f 1 8f 1 1
2 1840 20 1 20 1 1
1 1840 d7 1 c3 1 0
0 1840 d7 0 d7 1 0

/* compile.f */
hdl/soundIoPkg.sv
hdl/timingGen.sv
hdl/soundBusPort.sv
hdl/discreteSound.sv
hdl/arcadeSoundIo.sv
verification/arcadeSoundIoTb.sv

/* Bender.yml */
package:
  name: arcadeSoundIo

dependencies: {}

sources:
  # design
  - hdl/soundIoPkg.sv
  - hdl/timingGen.sv
  - hdl/soundBusPort.sv
  - hdl/discreteSound.sv
  - hdl/arcadeSoundIo.sv

  # testbench
  - target: test
    files:
      - verification/arcadeSoundIoTb.sv
